/* src/axis_types_pkg.sv */
package axis_types_pkg;

    // Host stream data width
    localparam int DATA_BITS = 64;

    // One beat on a host stream
    typedef struct packed {
        logic [DATA_BITS-1:0] data;
        logic                 last;
    } axis_beat_t;

endpackage

/* src/lynx_types_pkg.sv */
package lynx_types_pkg;

    // Buffer word address, transfer length and transfer id widths
    localparam int ADDR_BITS = 8;
    localparam int LEN_BITS  = 8;
    localparam int ID_BITS   = 4;

    // Submission queue descriptor, len counts beats minus one
    typedef struct packed {
        logic [ID_BITS-1:0]   id;
        logic [ADDR_BITS-1:0] addr;
        logic [LEN_BITS-1:0]  len;
    } req_t;

    // Completion queue entry
    typedef struct packed {
        logic [ID_BITS-1:0] id;
    } cq_t;

    // Notify entry raised at the end of a transfer
    typedef struct packed {
        logic [ID_BITS-1:0]  id;
        logic [LEN_BITS-1:0] len;
    } notify_t;

    // Control bus write request
    typedef struct packed {
        logic [7:0]  addr;
        logic [31:0] data;
    } ctrl_wr_t;

    // Register byte offsets
    localparam logic [7:0] REG_CTRL   = 8'h00;
    localparam logic [7:0] REG_SRC    = 8'h04;
    localparam logic [7:0] REG_DST    = 8'h08;
    localparam logic [7:0] REG_LEN    = 8'h0C;
    localparam logic [7:0] REG_STATUS = 8'h10;

    // Buffer memory access from the host side
    typedef struct packed {
        logic                                 we;
        logic [ADDR_BITS-1:0]                 addr;
        logic [axis_types_pkg::DATA_BITS-1:0] data;
    } host_mem_req_t;

endpackage

/* src/user_ctrl_regs.sv */
`timescale 1ns/1ns

module user_ctrl_regs #(
    parameter int DONE_BITS = 8
) (
    input  logic                                 aclk,
    input  logic                                 reset,
    input  lynx_types_pkg::ctrl_wr_t             ctrl_wr,
    input  logic                                 ctrl_wr_valid,
    output logic                                 ctrl_wr_ready,
    output logic                                 ctrl_bvalid,
    input  logic                                 ctrl_bready,
    input  logic [7:0]                           ctrl_raddr,
    input  logic                                 ctrl_ar_valid,
    output logic                                 ctrl_ar_ready,
    output logic [31:0]                          ctrl_rdata,
    output logic                                 ctrl_r_valid,
    input  logic                                 ctrl_r_ready,
    output logic                                 start,
    output logic [lynx_types_pkg::ADDR_BITS-1:0] src_addr,
    output logic [lynx_types_pkg::ADDR_BITS-1:0] dst_addr,
    output logic [lynx_types_pkg::LEN_BITS-1:0]  xfer_len,
    output logic [lynx_types_pkg::ID_BITS-1:0]   xfer_id,
    input  logic                                 busy,
    input  logic [DONE_BITS-1:0]                 done_count
);
    import lynx_types_pkg::*;

    logic        bus_en;
    logic        wr_fire;
    logic        ar_fire;
    logic [31:0] rd_word;

    // A held response blocks the next request on its channel
    assign ctrl_wr_ready = bus_en && !ctrl_bvalid;
    assign ctrl_ar_ready = bus_en && !ctrl_r_valid;
    assign wr_fire       = ctrl_wr_valid && ctrl_wr_ready;
    assign ar_fire       = ctrl_ar_valid && ctrl_ar_ready;

    // Read mux
    always_comb begin
        rd_word = '0;
        case (ctrl_raddr)
            REG_CTRL:   rd_word[4 +: ID_BITS] = xfer_id;
            REG_SRC:    rd_word[ADDR_BITS-1:0] = src_addr;
            REG_DST:    rd_word[ADDR_BITS-1:0] = dst_addr;
            REG_LEN:    rd_word[LEN_BITS-1:0] = xfer_len;
            REG_STATUS: begin
                rd_word[0]              = busy;
                rd_word[8 +: DONE_BITS] = done_count;
            end
            default:    rd_word = '0;
        endcase
    end

    always_ff @(posedge aclk) begin
        if (reset) begin
            bus_en       <= 1'b0;
            ctrl_bvalid  <= 1'b0;
            ctrl_r_valid <= 1'b0;
            start        <= 1'b0;
            src_addr     <= '0;
            dst_addr     <= '0;
            xfer_len     <= '0;
            xfer_id      <= '0;
        end else begin
            bus_en <= 1'b1;
            start  <= 1'b0;
            if (wr_fire)
                ctrl_bvalid <= 1'b1;
            else if (ctrl_bready)
                ctrl_bvalid <= 1'b0;
            if (ar_fire)
                ctrl_r_valid <= 1'b1;
            else if (ctrl_r_ready)
                ctrl_r_valid <= 1'b0;
            if (wr_fire) begin
                case (ctrl_wr.addr)
                    // Start is dropped while a transfer runs
                    REG_CTRL: begin
                        if (!busy) begin
                            start   <= 1'b1;
                            xfer_id <= ctrl_wr.data[4 +: ID_BITS];
                        end
                    end
                    REG_SRC: src_addr <= ctrl_wr.data[ADDR_BITS-1:0];
                    REG_DST: dst_addr <= ctrl_wr.data[ADDR_BITS-1:0];
                    REG_LEN: xfer_len <= ctrl_wr.data[LEN_BITS-1:0];
                    default: ;
                endcase
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (ar_fire)
            ctrl_rdata <= rd_word;
    end

endmodule

/* src/user_logic.sv */
`timescale 1ns/1ns

module user_logic #(
    parameter int DONE_BITS = 8
) (
    input  logic                        aclk,
    input  logic                        reset,
    input  lynx_types_pkg::ctrl_wr_t    ctrl_wr,
    input  logic                        ctrl_wr_valid,
    output logic                        ctrl_wr_ready,
    output logic                        ctrl_bvalid,
    input  logic                        ctrl_bready,
    input  logic [7:0]                  ctrl_raddr,
    input  logic                        ctrl_ar_valid,
    output logic                        ctrl_ar_ready,
    output logic [31:0]                 ctrl_rdata,
    output logic                        ctrl_r_valid,
    input  logic                        ctrl_r_ready,
    output lynx_types_pkg::req_t        sq_rd,
    output logic                        sq_rd_valid,
    input  logic                        sq_rd_ready,
    output lynx_types_pkg::req_t        sq_wr,
    output logic                        sq_wr_valid,
    input  logic                        sq_wr_ready,
    input  lynx_types_pkg::cq_t         cq_rd,
    input  logic                        cq_rd_valid,
    output logic                        cq_rd_ready,
    input  lynx_types_pkg::cq_t         cq_wr,
    input  logic                        cq_wr_valid,
    output logic                        cq_wr_ready,
    input  axis_types_pkg::axis_beat_t  host_resp,
    input  logic                        host_resp_valid,
    output logic                        host_resp_ready,
    output axis_types_pkg::axis_beat_t  host_send,
    output logic                        host_send_valid,
    input  logic                        host_send_ready,
    output lynx_types_pkg::notify_t     notify,
    output logic                        notify_valid,
    input  logic                        notify_ready
);
    import lynx_types_pkg::*;
    import axis_types_pkg::*;

    logic                 start;
    logic [ADDR_BITS-1:0] src_addr;
    logic [ADDR_BITS-1:0] dst_addr;
    logic [LEN_BITS-1:0]  xfer_len;
    logic [ID_BITS-1:0]   xfer_id;
    logic                 busy;
    logic [DONE_BITS-1:0] done_count;
    logic                 rd_done;
    logic                 wr_done;
    logic                 rd_hit;
    logic                 wr_hit;
    logic                 notify_fire;
    axis_beat_t           skid_q;
    logic                 skid_valid;

    user_ctrl_regs #(.DONE_BITS(DONE_BITS)) u_regs (.*);

    assign cq_rd_ready = 1'b1;
    assign cq_wr_ready = 1'b1;
    assign notify_fire = notify_valid && notify_ready;

    // Completions only count when they carry the running id
    assign rd_hit = rd_done || (busy && cq_rd_valid && cq_rd.id == notify.id);
    assign wr_hit = wr_done || (busy && cq_wr_valid && cq_wr.id == notify.id);

    always_ff @(posedge aclk) begin
        if (reset) begin
            sq_rd_valid  <= 1'b0;
            sq_wr_valid  <= 1'b0;
            busy         <= 1'b0;
            rd_done      <= 1'b0;
            wr_done      <= 1'b0;
            notify_valid <= 1'b0;
            done_count   <= '0;
        end else begin
            if (start) begin
                sq_rd_valid <= 1'b1;
                sq_wr_valid <= 1'b1;
                busy        <= 1'b1;
            end else begin
                if (sq_rd_ready)
                    sq_rd_valid <= 1'b0;
                if (sq_wr_ready)
                    sq_wr_valid <= 1'b0;
            end
            if (rd_hit && wr_hit && !notify_valid) begin
                notify_valid <= 1'b1;
                rd_done      <= 1'b0;
                wr_done      <= 1'b0;
            end else begin
                rd_done <= rd_hit;
                wr_done <= wr_hit;
            end
            if (notify_fire) begin
                notify_valid <= 1'b0;
                busy         <= 1'b0;
                done_count   <= done_count + 1'b1;
            end
        end
    end

    // Descriptors and notify payload, stable for the whole transfer
    always_ff @(posedge aclk) begin
        if (start) begin
            sq_rd  <= '{id: xfer_id, addr: src_addr, len: xfer_len};
            sq_wr  <= '{id: xfer_id, addr: dst_addr, len: xfer_len};
            notify <= '{id: xfer_id, len: xfer_len};
        end
    end

    // Two entry stream stage, skid entry catches the beat under back-pressure
    assign host_resp_ready = !skid_valid;

    always_ff @(posedge aclk) begin
        if (reset) begin
            host_send_valid <= 1'b0;
            skid_valid      <= 1'b0;
        end else if (!host_send_valid || host_send_ready) begin
            host_send_valid <= skid_valid || host_resp_valid;
            skid_valid      <= 1'b0;
        end else if (host_resp_valid && host_resp_ready) begin
            skid_valid <= 1'b1;
        end
    end

    always_ff @(posedge aclk) begin
        if (!host_send_valid || host_send_ready)
            host_send <= skid_valid ? skid_q : host_resp;
        else if (host_resp_valid && host_resp_ready)
            skid_q <= host_resp;
    end

endmodule

/* src/rd_dma_engine.sv */
`timescale 1ns/1ns

module rd_dma_engine (
    input  logic                                           aclk,
    input  logic                                           reset,
    input  lynx_types_pkg::req_t                           sq_rd,
    input  logic                                           sq_rd_valid,
    output logic                                           sq_rd_ready,
    output logic [lynx_types_pkg::ADDR_BITS-1:0]           mem_raddr,
    output logic                                           mem_ren,
    input  logic [axis_types_pkg::DATA_BITS-1:0]           mem_rdata,
    output axis_types_pkg::axis_beat_t                     host_resp,
    output logic                                           host_resp_valid,
    input  logic                                           host_resp_ready,
    output lynx_types_pkg::cq_t                            cq_rd,
    output logic                                           cq_rd_valid,
    input  logic                                           cq_rd_ready
);
    import lynx_types_pkg::*;

    logic                active;
    logic                issuing;
    logic [LEN_BITS-1:0] remain;
    logic [ID_BITS-1:0]  id_q;
    logic                last_q;
    logic                sq_fire;
    logic                last_fire;

    assign sq_rd_ready = !active && !cq_rd_valid;
    assign sq_fire     = sq_rd_valid && sq_rd_ready;
    assign last_fire   = host_resp_valid && host_resp_ready && last_q;

    // Memory output register doubles as the beat register
    assign mem_ren        = issuing && (!host_resp_valid || host_resp_ready);
    assign host_resp.data = mem_rdata;
    assign host_resp.last = last_q;
    assign cq_rd.id       = id_q;

    always_ff @(posedge aclk) begin
        if (reset) begin
            active          <= 1'b0;
            issuing         <= 1'b0;
            host_resp_valid <= 1'b0;
            cq_rd_valid     <= 1'b0;
        end else begin
            if (sq_fire) begin
                active  <= 1'b1;
                issuing <= 1'b1;
            end
            if (mem_ren) begin
                host_resp_valid <= 1'b1;
                if (remain == '0)
                    issuing <= 1'b0;
            end else if (host_resp_ready) begin
                host_resp_valid <= 1'b0;
            end
            if (last_fire) begin
                active      <= 1'b0;
                cq_rd_valid <= 1'b1;
            end else if (cq_rd_ready) begin
                cq_rd_valid <= 1'b0;
            end
        end
    end

    // Address walk, wraps in the buffer address space
    always_ff @(posedge aclk) begin
        if (sq_fire) begin
            mem_raddr <= sq_rd.addr;
            remain    <= sq_rd.len;
            id_q      <= sq_rd.id;
        end else if (mem_ren) begin
            mem_raddr <= mem_raddr + 1'b1;
            remain    <= remain - 1'b1;
        end
        if (mem_ren)
            last_q <= (remain == '0);
    end

endmodule

/* src/wr_dma_engine.sv */
`timescale 1ns/1ns

module wr_dma_engine (
    input  logic                           aclk,
    input  logic                           reset,
    input  lynx_types_pkg::req_t           sq_wr,
    input  logic                           sq_wr_valid,
    output logic                           sq_wr_ready,
    input  axis_types_pkg::axis_beat_t     host_send,
    input  logic                           host_send_valid,
    output logic                           host_send_ready,
    output lynx_types_pkg::host_mem_req_t  mem_wr,
    output logic                           mem_we,
    output lynx_types_pkg::cq_t            cq_wr,
    output logic                           cq_wr_valid,
    input  logic                           cq_wr_ready
);
    import lynx_types_pkg::*;

    logic                 has_desc;
    logic [ADDR_BITS-1:0] addr_q;
    logic [ID_BITS-1:0]   id_q;
    logic                 sq_fire;

    assign sq_wr_ready     = !has_desc && !cq_wr_valid;
    assign sq_fire         = sq_wr_valid && sq_wr_ready;
    assign host_send_ready = has_desc && !cq_wr_valid;

    // Accepted beat goes straight to the memory write port
    assign mem_we   = host_send_valid && host_send_ready;
    assign mem_wr   = '{we: 1'b1, addr: addr_q, data: host_send.data};
    assign cq_wr.id = id_q;

    always_ff @(posedge aclk) begin
        if (reset) begin
            has_desc    <= 1'b0;
            cq_wr_valid <= 1'b0;
        end else begin
            if (sq_fire)
                has_desc <= 1'b1;
            // The last flag ends the transfer whatever the length said
            if (mem_we && host_send.last) begin
                has_desc    <= 1'b0;
                cq_wr_valid <= 1'b1;
            end else if (cq_wr_ready) begin
                cq_wr_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (sq_fire) begin
            addr_q <= sq_wr.addr;
            id_q   <= sq_wr.id;
        end else if (mem_we) begin
            addr_q <= addr_q + 1'b1;
        end
    end

endmodule

/* src/buffer_mem.sv */
`timescale 1ns/1ns

module buffer_mem (
    input  logic                                 aclk,
    input  logic [lynx_types_pkg::ADDR_BITS-1:0] mem_raddr,
    input  logic                                 mem_ren,
    output logic [axis_types_pkg::DATA_BITS-1:0] mem_rdata,
    input  lynx_types_pkg::host_mem_req_t        mem_wr,
    input  logic                                 mem_we,
    input  lynx_types_pkg::host_mem_req_t        host_mem,
    input  logic                                 host_mem_valid,
    output logic                                 host_mem_ready,
    output logic [axis_types_pkg::DATA_BITS-1:0] host_rdata,
    output logic                                 host_rvalid
);
    import lynx_types_pkg::*;
    import axis_types_pkg::*;

    logic [DATA_BITS-1:0] mem [2**ADDR_BITS];

    // Write engine wins port B
    assign host_mem_ready = !mem_we;

    // Port A, engine reads
    always_ff @(posedge aclk) begin
        if (mem_ren)
            mem_rdata <= mem[mem_raddr];
    end

    // Port B, engine writes and host accesses
    always_ff @(posedge aclk) begin
        if (mem_we)
            mem[mem_wr.addr] <= mem_wr.data;
        else if (host_mem_valid && host_mem.we)
            mem[host_mem.addr] <= host_mem.data;
        host_rdata  <= mem[host_mem.addr];
        host_rvalid <= host_mem_valid && host_mem_ready && !host_mem.we;
    end

endmodule

/* src/vfpga_top.sv */
`timescale 1ns/1ns

module vfpga_top #(
    parameter int DONE_BITS = 8
) (
    input  logic                                 aclk,
    input  logic                                 reset,
    input  lynx_types_pkg::ctrl_wr_t             ctrl_wr,
    input  logic                                 ctrl_wr_valid,
    output logic                                 ctrl_wr_ready,
    output logic                                 ctrl_bvalid,
    input  logic                                 ctrl_bready,
    input  logic [7:0]                           ctrl_raddr,
    input  logic                                 ctrl_ar_valid,
    output logic                                 ctrl_ar_ready,
    output logic [31:0]                          ctrl_rdata,
    output logic                                 ctrl_r_valid,
    input  logic                                 ctrl_r_ready,
    input  lynx_types_pkg::host_mem_req_t        host_mem,
    input  logic                                 host_mem_valid,
    output logic                                 host_mem_ready,
    output logic [axis_types_pkg::DATA_BITS-1:0] host_rdata,
    output logic                                 host_rvalid,
    output lynx_types_pkg::notify_t              notify,
    output logic                                 notify_valid,
    input  logic                                 notify_ready
);
    import lynx_types_pkg::*;
    import axis_types_pkg::*;

    // Descriptor and completion queues
    req_t                 sq_rd;
    logic                 sq_rd_valid;
    logic                 sq_rd_ready;
    req_t                 sq_wr;
    logic                 sq_wr_valid;
    logic                 sq_wr_ready;
    cq_t                  cq_rd;
    logic                 cq_rd_valid;
    logic                 cq_rd_ready;
    cq_t                  cq_wr;
    logic                 cq_wr_valid;
    logic                 cq_wr_ready;

    // Host streams
    axis_beat_t           host_resp;
    logic                 host_resp_valid;
    logic                 host_resp_ready;
    axis_beat_t           host_send;
    logic                 host_send_valid;
    logic                 host_send_ready;

    // Engine side of the buffer memory
    logic [ADDR_BITS-1:0] mem_raddr;
    logic                 mem_ren;
    logic [DATA_BITS-1:0] mem_rdata;
    host_mem_req_t        mem_wr;
    logic                 mem_we;

    user_logic #(.DONE_BITS(DONE_BITS)) u_user_logic (.*);

    rd_dma_engine u_rd_dma (.*);

    wr_dma_engine u_wr_dma (.*);

    buffer_mem u_buffer_mem (.*);

endmodule

/* tests/user_logic_checker.sv */
`timescale 1ns/1ns

module user_logic_checker (
    input logic                       aclk,
    input logic                       reset,
    input lynx_types_pkg::req_t       sq_rd,
    input logic                       sq_rd_valid,
    input logic                       sq_rd_ready,
    input lynx_types_pkg::req_t       sq_wr,
    input logic                       sq_wr_valid,
    input logic                       sq_wr_ready,
    input logic                       busy,
    input logic                       notify_valid,
    input axis_types_pkg::axis_beat_t host_send,
    input logic                       host_send_valid,
    input logic                       host_send_ready
);

    // Descriptors wait unchanged for their engine
    sq_rd_stable: assert property (@(posedge aclk) disable iff (reset)
        sq_rd_valid && !sq_rd_ready |=> sq_rd_valid && $stable(sq_rd))
        else $error("sq_rd descriptor changed before it was taken");

    sq_wr_stable: assert property (@(posedge aclk) disable iff (reset)
        sq_wr_valid && !sq_wr_ready |=> sq_wr_valid && $stable(sq_wr))
        else $error("sq_wr descriptor changed before it was taken");

    notify_in_busy: assert property (@(posedge aclk) disable iff (reset)
        notify_valid |-> busy)
        else $error("notify valid while the transfer is not busy");

    // A stalled beat stays on the stream
    beat_held: assert property (@(posedge aclk) disable iff (reset)
        host_send_valid && !host_send_ready |=> host_send_valid && $stable(host_send))
        else $error("host_send beat lost under back-pressure");

endmodule

/* tests/tb_top.sv */
`timescale 1ns/1ns

module tb_top;
    import lynx_types_pkg::*;
    import axis_types_pkg::*;

    localparam int TIMEOUT = 200;

    logic                 aclk;
    logic                 reset;
    ctrl_wr_t             ctrl_wr;
    logic                 ctrl_wr_valid;
    logic                 ctrl_wr_ready;
    logic                 ctrl_bvalid;
    logic                 ctrl_bready;
    logic [7:0]           ctrl_raddr;
    logic                 ctrl_ar_valid;
    logic                 ctrl_ar_ready;
    logic [31:0]          ctrl_rdata;
    logic                 ctrl_r_valid;
    logic                 ctrl_r_ready;
    host_mem_req_t        host_mem;
    logic                 host_mem_valid;
    logic                 host_mem_ready;
    logic [DATA_BITS-1:0] host_rdata;
    logic                 host_rvalid;
    notify_t              notify;
    logic                 notify_valid;
    logic                 notify_ready;

    // Shadow copy of the buffer memory
    logic [DATA_BITS-1:0] model [256];
    logic [7:0]           exp_done;
    integer               seed;
    int                   data_errors;
    int                   reg_errors;
    int                   notify_errors;
    int                   timeout_errors;
    int                   reset_errors;

    vfpga_top #(.DONE_BITS(8)) DUT (.*);

    bind user_logic user_logic_checker u_checker (.*);

    initial begin
        aclk = 1'b0;
        forever #4 aclk = ~aclk;
    end

    task automatic check_word(input string test, input logic [DATA_BITS-1:0] exp,
                              input logic [DATA_BITS-1:0] act);
        if (act !== exp) begin
            $display("** Error [%s] expected %h, actual %h", test, exp, act);
            data_errors++;
        end
    endtask

    task automatic check_reg(input string test, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            $display("** Error [%s] expected %h, actual %h", test, exp, act);
            reg_errors++;
        end
    endtask

    task automatic check_notify(input string test, input notify_t exp, input notify_t act);
        if (act !== exp) begin
            $display("** Error [%s] expected id %0d len %0d, actual id %0d len %0d",
                     test, exp.id, exp.len, act.id, act.len);
            notify_errors++;
        end
    endtask

    task automatic report_timeout(input string what);
        $display("Timeout: no %s within %0d cycles", what, TIMEOUT);
        timeout_errors++;
    endtask

    // Every valid output and the write ready sit low while reset holds
    task automatic check_reset_outputs();
        if ({ctrl_wr_ready, ctrl_bvalid, ctrl_r_valid, host_rvalid, notify_valid} !== 5'b0) begin
            $display("Reset: a valid output or ctrl_wr_ready is not low under reset");
            reset_errors++;
        end
    endtask

    // Bus tasks start and end on a falling edge
    task automatic ctrl_write(input logic [7:0] addr, input logic [31:0] data);
        int t;
        ctrl_wr = '{addr: addr, data: data};
        ctrl_wr_valid = 1'b1;
        t = 0;
        while (!ctrl_wr_ready && t < TIMEOUT) begin
            @(negedge aclk);
            t++;
        end
        if (!ctrl_wr_ready)
            report_timeout("control write ready");
        @(negedge aclk);
        ctrl_wr_valid = 1'b0;
        t = 0;
        while (!ctrl_bvalid && t < TIMEOUT) begin
            @(negedge aclk);
            t++;
        end
        if (!ctrl_bvalid)
            report_timeout("control write response");
        @(negedge aclk);
    endtask

    task automatic ctrl_read(input logic [7:0] addr, output logic [31:0] data);
        int t;
        ctrl_raddr = addr;
        ctrl_ar_valid = 1'b1;
        t = 0;
        while (!ctrl_ar_ready && t < TIMEOUT) begin
            @(negedge aclk);
            t++;
        end
        if (!ctrl_ar_ready)
            report_timeout("control read address ready");
        @(negedge aclk);
        ctrl_ar_valid = 1'b0;
        t = 0;
        while (!ctrl_r_valid && t < TIMEOUT) begin
            @(negedge aclk);
            t++;
        end
        if (!ctrl_r_valid)
            report_timeout("control read data");
        data = ctrl_rdata;
        @(negedge aclk);
    endtask

    task automatic mem_access(input logic we, input logic [ADDR_BITS-1:0] addr,
                              input logic [DATA_BITS-1:0] data);
        int t;
        host_mem = '{we: we, addr: addr, data: data};
        host_mem_valid = 1'b1;
        t = 0;
        while (!host_mem_ready && t < TIMEOUT) begin
            @(negedge aclk);
            t++;
        end
        if (!host_mem_ready)
            report_timeout("host memory ready");
        @(negedge aclk);
        host_mem_valid = 1'b0;
    endtask

    task automatic mem_write(input logic [ADDR_BITS-1:0] addr, input logic [DATA_BITS-1:0] data);
        mem_access(1'b1, addr, data);
        model[addr] = data;
    endtask

    task automatic mem_read(input logic [ADDR_BITS-1:0] addr, output logic [DATA_BITS-1:0] data);
        int t;
        mem_access(1'b0, addr, '0);
        t = 0;
        while (!host_rvalid && t < TIMEOUT) begin
            @(negedge aclk);
            t++;
        end
        if (!host_rvalid)
            report_timeout("host read data");
        data = host_rdata;
    endtask

    task automatic fill_random(input logic [ADDR_BITS-1:0] base, input int count);
        int k;
        for (k = 0; k < count; k++)
            mem_write(base + ADDR_BITS'(k), {$random(seed), $random(seed)});
    endtask

    task automatic start_copy(input logic [ADDR_BITS-1:0] src, input logic [ADDR_BITS-1:0] dst,
                              input logic [LEN_BITS-1:0] len, input logic [ID_BITS-1:0] id);
        ctrl_write(REG_SRC, 32'(src));
        ctrl_write(REG_DST, 32'(dst));
        ctrl_write(REG_LEN, 32'(len));
        ctrl_write(REG_CTRL, 32'({id, 4'b0}));
    endtask

    task automatic wait_notify();
        int t;
        t = 0;
        while (!notify_valid && t < TIMEOUT) begin
            @(negedge aclk);
            t++;
        end
        if (!notify_valid)
            report_timeout("notify");
    endtask

    task automatic take_notify(input string test, input logic [ID_BITS-1:0] id,
                               input logic [LEN_BITS-1:0] len);
        notify_t exp;
        exp = '{id: id, len: len};
        wait_notify();
        check_notify(test, exp, notify);
        notify_ready = 1'b1;
        @(negedge aclk);
        notify_ready = 1'b0;
        exp_done = exp_done + 1'b1;
    endtask

    // Source and destination ranges never overlap, so the model copies word by word
    task automatic verify_copy(input string test, input logic [ADDR_BITS-1:0] src,
                               input logic [ADDR_BITS-1:0] dst, input logic [LEN_BITS-1:0] len);
        int                   k;
        logic [ADDR_BITS-1:0] d;
        logic [DATA_BITS-1:0] w;
        for (k = 0; k <= int'(len); k++) begin
            d = dst + ADDR_BITS'(k);
            model[d] = model[src + ADDR_BITS'(k)];
            mem_read(d, w);
            check_word(test, model[d], w);
        end
    endtask

    task automatic verify_status(input string test, input logic busy_exp);
        logic [31:0] exp;
        logic [31:0] rd;
        exp = '0;
        exp[0] = busy_exp;
        exp[15:8] = exp_done;
        ctrl_read(REG_STATUS, rd);
        check_reg(test, exp, rd);
    endtask

    task automatic copy_and_check(input string test, input logic [ADDR_BITS-1:0] src,
                                  input logic [ADDR_BITS-1:0] dst,
                                  input logic [LEN_BITS-1:0] len, input logic [ID_BITS-1:0] id);
        start_copy(src, dst, len, id);
        take_notify(test, id, len);
        verify_copy(test, src, dst, len);
    endtask

    task automatic reg_readback();
        int          i;
        logic [7:0]  addr;
        logic [31:0] v;
        logic [31:0] rd;
        verify_status("reg_readback", 1'b0);
        for (i = 0; i < 3; i++) begin
            addr = REG_SRC + 8'(4 * i);
            v = $random(seed) & 32'hFF;
            ctrl_write(addr, v);
            ctrl_read(addr, rd);
            check_reg("reg_readback", v, rd);
        end
    endtask

    task automatic single_copy();
        fill_random(8'h10, 8);
        copy_and_check("single_copy", 8'h10, 8'h80, 8'd7, 4'd3);
        verify_status("single_copy", 1'b0);
    endtask

    task automatic notify_backpressure();
        int          k;
        logic [31:0] rd;
        fill_random(8'h40, 4);
        start_copy(8'h40, 8'hC0, 8'd3, 4'd5);
        wait_notify();
        for (k = 0; k < 16; k++) begin
            @(negedge aclk);
            if (!notify_valid) begin
                $display("notify_backpressure: notify dropped before it was accepted");
                notify_errors++;
            end
        end
        verify_status("notify_backpressure", 1'b1);
        // Start while busy must leave the running id in place
        ctrl_write(REG_CTRL, 32'h90);
        ctrl_read(REG_CTRL, rd);
        check_reg("notify_backpressure", 32'h50, rd);
        take_notify("notify_backpressure", 4'd5, 8'd3);
        for (k = 0; k < 32; k++) begin
            @(negedge aclk);
            if (notify_valid) begin
                $display("notify_backpressure: a second notify followed the ignored start");
                notify_errors++;
            end
        end
        verify_copy("notify_backpressure", 8'h40, 8'hC0, 8'd3);
        verify_status("notify_backpressure", 1'b0);
    endtask

    task automatic wrap_and_len_zero();
        logic [DATA_BITS-1:0] w;
        fill_random(8'h20, 1);
        mem_write(8'h31, 64'h0123_4567_89ab_cdef);
        copy_and_check("len_zero", 8'h20, 8'h30, 8'd0, 4'd1);
        mem_read(8'h31, w);
        check_word("len_zero", model[8'h31], w);
        fill_random(8'hFC, 8);
        copy_and_check("wrap_src", 8'hFC, 8'h60, 8'd7, 4'd2);
        fill_random(8'h70, 8);
        copy_and_check("wrap_dst", 8'h70, 8'hFC, 8'd7, 4'd4);
    endtask

    task automatic back_to_back();
        int                  i;
        logic [LEN_BITS-1:0] lens [4];
        for (i = 0; i < 4; i++) begin
            lens[i] = LEN_BITS'($random(seed) & 15);
            fill_random(ADDR_BITS'(i * 16), int'(lens[i]) + 1);
        end
        for (i = 0; i < 4; i++) begin
            start_copy(ADDR_BITS'(i * 16), 8'h80 + ADDR_BITS'(i * 16), lens[i], ID_BITS'(i));
            take_notify("back_to_back", ID_BITS'(i), lens[i]);
        end
        for (i = 0; i < 4; i++)
            verify_copy("back_to_back", ADDR_BITS'(i * 16), 8'h80 + ADDR_BITS'(i * 16), lens[i]);
        verify_status("back_to_back", 1'b0);
    endtask

    initial begin
        seed = 32'hb749;
        exp_done = '0;
        data_errors = 0;
        reg_errors = 0;
        notify_errors = 0;
        timeout_errors = 0;
        reset_errors = 0;
        reset = 1'b1;
        ctrl_wr = '0;
        ctrl_wr_valid = 1'b0;
        ctrl_bready = 1'b1;
        ctrl_raddr = '0;
        ctrl_ar_valid = 1'b0;
        ctrl_r_ready = 1'b1;
        host_mem = '0;
        host_mem_valid = 1'b0;
        notify_ready = 1'b0;
        repeat (4) @(negedge aclk);
        check_reset_outputs();
        reset = 1'b0;
        @(negedge aclk);

        reg_readback();
        single_copy();
        notify_backpressure();
        wrap_and_len_zero();
        back_to_back();

        $display("Error counts: data %0d, register %0d, notify %0d, timeout %0d, reset %0d",
                 data_errors, reg_errors, notify_errors, timeout_errors, reset_errors);
        if (data_errors + reg_errors + notify_errors + timeout_errors + reset_errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

/* sources.f */
src/axis_types_pkg.sv
src/lynx_types_pkg.sv
src/user_ctrl_regs.sv
src/user_logic.sv
src/rd_dma_engine.sv
src/wr_dma_engine.sv
src/buffer_mem.sv
src/vfpga_top.sv
tests/user_logic_checker.sv
tests/tb_top.sv

/* run_sim.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --top-module tb_top -f sources.f -o tb_sim; then
    echo "Verilator build failed"
    exit 1
fi

if ! output=$(./obj_dir/tb_sim); then
    echo "$output"
    echo "Simulation returned a failing status"
    exit 1
fi
echo "$output"

if echo "$output" | grep -qF '*** PASSED ***'; then
    exit 0
fi
exit 1
